//--- sim.f
common/uart_pkg.sv
design/char_fifo.sv
uart/serial_tx.sv
uart/serial_rx.sv
design/uart_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv

//--- Makefile
# Verilator build and run of the UART testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module tb_top -Mdir obj_dir -f sim.f

run: compile
	./obj_dir/Vtb_top > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/tb_top.sv
`timescale 1ns/1ps
// UART testbench, all stimulus changes on the falling clock edge
// rxd is txd in loopback, otherwise a bit-bang line driver
// random stimulus from one seeded $random stream

module tb_top
  import uart_pkg::*;
();

  localparam int clk_freq    = 125_000_000;
  localparam int bit_freq    = 7_812_500;
  localparam int fifo_depth  = 8;
  localparam int period      = bit_period(clk_freq, bit_freq);
  localparam int write_limit = 4 * frame_bits * period;  // one write may stall this long
  localparam int drain_limit = 40 * frame_bits * period; // all traffic settles

  logic       clk, arst_n;
  logic       tx_valid, tx_ready, rx_valid, rx_frame_err, txd, rxd, overrun;
  logic [7:0] tx_data, rx_data;
  logic       rx_ready = 1'b0;
  logic       loop_sel, bb_line;  // line select, bit-bang level
  logic       exp_valid, test_done, exp_stall;
  logic [9:0] exp_frame;
  int         test_id, exp_overruns, pending, tests_run, tests_failed, errors;
  int         seed    = 72653;
  int         rx_mode = 1;        // 0 hold off, 1 always ready, 2 random
  logic [31:0] rnd;

  assign rxd = loop_sel ? txd : bb_line;

  tb_clock #(.period_ns(8), .reset_cycles(16)) i_clock (.clk(clk), .arst_n(arst_n));

  uart_top #(
    .clk_freq   (clk_freq),
    .bit_freq   (bit_freq),
    .fifo_depth (fifo_depth)
  ) i_uart_top (
    .clk(clk), .arst_n(arst_n),
    .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready),
    .rx_valid(rx_valid), .rx_data(rx_data), .rx_frame_err(rx_frame_err), .rx_ready(rx_ready),
    .rxd(rxd), .txd(txd), .overrun(overrun)
  );

  tb_checker #(.clk_freq(clk_freq), .bit_freq(bit_freq)) i_checker (
    .clk(clk), .arst_n(arst_n),
    .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_data(tx_data), .txd(txd),
    .rx_valid(rx_valid), .rx_ready(rx_ready), .rx_frame_err(rx_frame_err), .rx_data(rx_data),
    .overrun(overrun), .loop_sel(loop_sel), .exp_valid(exp_valid), .exp_frame(exp_frame),
    .test_done(test_done), .exp_stall(exp_stall), .test_id(test_id),
    .exp_overruns(exp_overruns), .pending(pending), .tests_run(tests_run),
    .tests_failed(tests_failed), .errors(errors)
  );

  // one random word per cycle, settled before the falling edge reads it
  always @(posedge clk)
  begin
    rnd = $random(seed);
  end

  // host read back-pressure
  always @(negedge clk)
  begin
    case (rx_mode)
      0:       rx_ready = 1'b0;
      1:       rx_ready = 1'b1;
      default: rx_ready = rnd[8];
    endcase
  end

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("Test FAILED");
    $finish;
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic write_byte(input logic [7:0] b);
    int n;
    n        = 0;
    tx_valid = 1'b1;
    tx_data  = b;
    while (tx_ready !== 1'b1 && n < write_limit)
    begin
      @(negedge clk);
      n++;
    end
    if (tx_ready !== 1'b1)
      abort_run("tx_ready stayed low, byte never accepted");
    else
    begin
      @(negedge clk); // taken on the rising edge before
      tx_valid = 1'b0;
    end
  endtask

  // bit-bang one frame on rxd, optionally telling the checker to expect it
  task automatic send_frame(input logic [9:0] frame, input logic announce);
    if (announce)
    begin
      exp_frame = frame;
      exp_valid = 1'b1;
      @(negedge clk);
      exp_valid = 1'b0;
    end
    for (int i = 0; i < frame_bits; i++)
    begin
      bb_line = frame[i]; // lsb first
      repeat (period) @(negedge clk);
    end
    bb_line = stop_bit;
    repeat (2 * period) @(negedge clk); // idle gap
  endtask

  task automatic wait_drained(input string what);
    int n;
    n = 0;
    while (pending != 0 && n < drain_limit)
    begin
      @(negedge clk);
      n++;
    end
    if (pending != 0)
      abort_run($sformatf("%s never arrived", what));
  endtask

  task automatic end_test(input int id, input int ovr, input logic stall);
    test_id      = id;
    exp_overruns = ovr;
    exp_stall    = stall;
    test_done    = 1'b1;
    @(negedge clk);
    test_done    = 1'b0;
  endtask

  initial
  begin : stimulus
    int n;
    tx_valid     = 1'b0;
    tx_data      = '0;
    bb_line      = stop_bit;
    loop_sel     = 1'b0;
    exp_valid    = 1'b0;
    exp_frame    = '1;
    test_done    = 1'b0;
    exp_stall    = 1'b0;
    test_id      = 0;
    exp_overruns = 0;
    n            = 0;
    while (arst_n !== 1'b1 && n < 100)
    begin
      @(negedge clk);
      n++;
    end
    if (arst_n !== 1'b1)
      abort_run("reset was never released");
    else
    begin
      @(negedge clk);
      end_test(1, 0, 1'b0); // reset state checked on the first edge
      for (int i = 0; i < 4; i++)
        write_byte(rnd[7:0]);
      wait_drained("transmit frames");
      end_test(2, 0, 1'b0);
      loop_sel = 1'b1;
      rx_mode  <= 2;
      for (int i = 0; i < 20; i++)
        write_byte(rnd[7:0]);
      wait_drained("loopback characters");
      end_test(3, 0, 1'b0);
      loop_sel = 1'b0;
      rx_mode  <= 1;
      send_frame({~stop_bit, rnd[7:0], start_bit}, 1'b1); // stop bit low
      send_frame({stop_bit, rnd[7:0], start_bit}, 1'b1);
      wait_drained("framing error characters");
      end_test(4, 0, 1'b0);
      bb_line = start_bit; // glitch of a quarter bit
      repeat (period / 4) @(negedge clk);
      bb_line = stop_bit;
      repeat (3 * period) @(negedge clk);
      send_frame({stop_bit, rnd[7:0], start_bit}, 1'b1);
      wait_drained("character after a false start");
      end_test(5, 0, 1'b0);
      rx_mode <= 0;
      fork
        for (int i = 0; i < fifo_depth + 4; i++)
          write_byte(rnd[7:0]);
        for (int i = 0; i < fifo_depth + 2; i++)
          send_frame({stop_bit, rnd[15:8], start_bit}, i < fifo_depth); // last two dropped
      join
      rx_mode <= 1;
      wait_drained("buffered characters");
      end_test(6, 2, 1'b1);
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (tests_failed == 0 && errors == 0)
        $display("Test OK");
      else
        $display("Test FAILED");
      $finish;
    end
  end

endmodule

//--- test/tb_checker.sv
`timescale 1ns/1ps
// watches the UART ports and compares them with expected frames and characters
// expectations come from host writes, and from frames that tb_top announces
// txd is sampled at mid-bit, timed from each falling edge

module tb_checker
  import uart_pkg::*;
#(
  parameter int clk_freq = 125_000_000,
  parameter int bit_freq = 7_812_500
) (
  input  logic       clk, arst_n,
  input  logic       tx_valid, tx_ready, // host write side
  input  logic [7:0] tx_data,
  input  logic       txd,
  input  logic       rx_valid, rx_ready, rx_frame_err, // host read side
  input  logic [7:0] rx_data,
  input  logic       overrun,
  input  logic       loop_sel,  // rxd tied to txd
  input  logic       exp_valid, // a driven frame to expect back
  input  logic [9:0] exp_frame,
  input  logic       test_done, exp_stall,
  input  int         test_id, exp_overruns,
  output int         pending,   // frames and chars not yet seen
  output int         tests_run, tests_failed, errors
);

  localparam int period = bit_period(clk_freq, bit_freq);

  logic [9:0] txq[$];  // frames expected on txd
  rx_char_t   rxq[$];  // entries expected at the host read side
  logic [9:0] cap_bits;
  logic       txd_prev, cap_active, reset_checked, stall_seen;
  int         cap_cnt, cap_idx, overruns_seen, err_mark;

  // 8N1 frame as it leaves the line, bit 0 first
  function automatic logic [9:0] frame_of(input logic [7:0] b);
    return {stop_bit, b, start_bit};
  endfunction

  // what the receiver should deliver for a frame on rxd
  function automatic rx_char_t char_of(input logic [9:0] frame);
    rx_char_t c;
    c.data      = frame[8:1];
    c.frame_err = (frame[9] != stop_bit); // low stop level
    return c;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1: return "reset state";
      2: return "transmit framing";
      3: return "loopback";
      4: return "framing error";
      5: return "false start";
      6: return "overrun and write back-pressure";
      default: return "unknown";
    endcase
  endfunction

  task automatic flag_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    errors++;
  endtask

  always @(posedge clk)
  begin : monitor
    rx_char_t   want;
    logic [9:0] sent;
    int         t_err;
    if (!arst_n)
    begin
      txq.delete();
      rxq.delete();
      txd_prev      = 1'b1;
      cap_active    = 1'b0;
      reset_checked = 1'b0;
      stall_seen    = 1'b0;
      overruns_seen = 0;
      err_mark      = 0;
      tests_run     = 0;
      tests_failed  = 0;
      errors        = 0;
    end
    else
    begin
      if (!reset_checked) // first edge out of reset
      begin
        reset_checked = 1'b1;
        if (txd !== stop_bit || rx_valid !== 1'b0 || tx_ready !== 1'b1 || overrun !== 1'b0)
          flag_error($sformatf("after reset txd %b rx_valid %b tx_ready %b overrun %b",
                               txd, rx_valid, tx_ready, overrun));
      end
      if (tx_valid && tx_ready) // byte accepted
      begin
        txq.push_back(frame_of(tx_data));
        if (loop_sel)
          rxq.push_back(char_of(frame_of(tx_data))); // comes straight back
      end
      if (tx_valid && !tx_ready)
        stall_seen = 1'b1;
      if (exp_valid)
        rxq.push_back(char_of(exp_frame));
      if (overrun)
        overruns_seen++;
      if (!cap_active)
      begin
        if (txd_prev == stop_bit && txd == start_bit) // falling edge
        begin
          cap_active = 1'b1;
          cap_cnt    = period / 2 - 1; // to middle of start bit
          cap_idx    = 0;
        end
      end
      else if (cap_cnt != 0)
        cap_cnt--;
      else
      begin
        cap_bits[cap_idx] = txd; // mid-bit sample
        if (cap_idx == frame_bits - 1)
        begin
          cap_active = 1'b0;
          if (txq.size() == 0)
            flag_error($sformatf("frame %b on txd with no byte written", cap_bits));
          else
          begin
            sent = txq.pop_front();
            if (cap_bits !== sent)
              flag_error($sformatf("txd frame %b, expected %b", cap_bits, sent));
          end
        end
        else
        begin
          cap_idx++;
          cap_cnt = period - 1; // one bit later
        end
      end
      if (rx_valid && rx_ready) // host takes a character
      begin
        if (rxq.size() == 0)
          flag_error($sformatf("character 0x%h err %b with none expected", rx_data, rx_frame_err));
        else
        begin
          want = rxq.pop_front();
          if (rx_data !== want.data || rx_frame_err !== want.frame_err)
            flag_error($sformatf("received 0x%h err %b, expected 0x%h err %b",
                                 rx_data, rx_frame_err, want.data, want.frame_err));
        end
      end
      if (test_done)
      begin
        if (overruns_seen != exp_overruns)
          flag_error($sformatf("%0d overrun pulses, expected %0d", overruns_seen, exp_overruns));
        if (exp_stall && !stall_seen)
          flag_error("tx_ready never fell during the write burst");
        if (txq.size() != 0 || rxq.size() != 0)
          flag_error($sformatf("%0d frames and %0d characters never seen", txq.size(), rxq.size()));
        t_err = errors - err_mark;
        tests_run++;
        if (t_err != 0)
          tests_failed++;
        $display("test %0d %s: %s, %0d errors", test_id, test_name(test_id),
                 (t_err == 0) ? "passed" : "failed", t_err);
        err_mark      = errors;
        overruns_seen = 0;
        stall_seen    = 1'b0;
      end
      txd_prev = txd;
      pending  = txq.size() + rxq.size() + (cap_active ? 1 : 0);
    end
  end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps
// testbench clock and power-on reset
// reset is released on a falling edge, away from the DUT's sampling edge

module tb_clock #(
  parameter int period_ns    = 8,  // clock period
  parameter int reset_cycles = 16  // rising edges held in reset
) (
  output logic clk,
  output logic arst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial
  begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1; // released mid-cycle
  end

endmodule

//--- design/uart_top.sv
`timescale 1ns/1ps
// UART with a transmit FIFO and a receive FIFO on the host side
// 8N1 only, no flow control; host bytes wait until the line is free
// a received character finding the FIFO full is dropped and overrun pulses

module uart_top
  import uart_pkg::*;
#(
  parameter int clk_freq   = 125_000_000, // Hz
  parameter int bit_freq   = 7_812_500,   // baud, 16 clocks per bit here
  parameter int fifo_depth = 8            // each FIFO, power of two
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       tx_valid,     // host write
  input  logic [7:0] tx_data,
  output logic       tx_ready,
  output logic       rx_valid,     // host read
  output logic [7:0] rx_data,
  output logic       rx_frame_err, // stop bit of this char was low
  input  logic       rx_ready,
  input  logic       rxd,          // line in
  output logic       txd,          // line out
  output logic       overrun       // one-cycle pulse per dropped char
);

  logic       ser_valid;   // tx FIFO head ready to send
  logic [7:0] ser_data;
  logic       ser_ready;   // transmitter idle
  logic       char_valid;  // receiver pulse
  logic [7:0] char_data;
  logic       char_err;
  logic       rx_room;     // rx FIFO not full
  rx_char_t   rx_wr_entry;
  rx_char_t   rx_rd_entry;

  char_fifo #(
    .fifo_depth (fifo_depth),
    .payload_t  (byte)
  ) i_tx_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (tx_valid),
    .in_data   (tx_data),
    .in_ready  (tx_ready),
    .out_valid (ser_valid),
    .out_data  (ser_data),
    .out_ready (ser_ready)
  );

  serial_tx #(
    .clk_freq (clk_freq),
    .bit_freq (bit_freq)
  ) i_serial_tx (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (ser_valid),
    .in_data  (ser_data),
    .in_ready (ser_ready),
    .txd      (txd)
  );

  serial_rx #(
    .clk_freq (clk_freq),
    .bit_freq (bit_freq)
  ) i_serial_rx (
    .clk        (clk),
    .arst_n     (arst_n),
    .rxd        (rxd),
    .char_valid (char_valid),
    .char_data  (char_data),
    .char_err   (char_err)
  );

  assign rx_wr_entry = '{frame_err: char_err, data: char_data};

  char_fifo #(
    .fifo_depth (fifo_depth),
    .payload_t  (rx_char_t)
  ) i_rx_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (char_valid), // no hold, a full FIFO drops it
    .in_data   (rx_wr_entry),
    .in_ready  (rx_room),
    .out_valid (rx_valid),
    .out_data  (rx_rd_entry),
    .out_ready (rx_ready)
  );

  assign rx_data      = rx_rd_entry.data;
  assign rx_frame_err = rx_rd_entry.frame_err;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      overrun <= 1'b0;
    else
      overrun <= char_valid && !rx_room; // char lost
  end

endmodule

//--- uart/serial_rx.sv
`timescale 1ns/1ps
// 8N1 receiver, one sample per bit at mid-bit
// no re-sync on edges inside a frame, so the baud ratio must be accurate
// char_valid is a single-cycle pulse with no back-pressure

module serial_rx
  import uart_pkg::*;
#(
  parameter int clk_freq = 125_000_000, // Hz
  parameter int bit_freq = 7_812_500    // baud
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       rxd,        // async line in
  output logic       char_valid, // pulse at mid stop bit
  output logic [7:0] char_data,  // lsb arrives first
  output logic       char_err    // stop bit was low
);

  localparam int period    = bit_period(clk_freq, bit_freq);
  localparam int full_time = period - 1;        // reload for a whole bit
  localparam int half_time = (period >> 1) - 1; // edge to mid-bit
  localparam int tw        = $clog2(period);

  logic [2:0]    sync;  // three-stage synchronizer
  logic          rx_in; // synchronized line level
  logic [tw-1:0] timer; // down-counter to next sample
  logic [3:0]    bits;  // 0 hunt, 1 start, 2..9 data, 10 stop
  logic          sample_data; // shift enable for the data register

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      sync <= '1; // idle line is high
    else
      sync <= {sync[1:0], rxd};
  end

  assign rx_in = sync[2];

  // start bit and data bits all shift in, start drops out the bottom
  assign sample_data = (timer == '0) && (bits != 4'd0) && (bits != 4'(frame_bits));

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      timer      <= '0;
      bits       <= '0;
      char_valid <= 1'b0;
      char_err   <= 1'b0;
    end
    else
    begin
      char_valid <= 1'b0; // single-cycle pulse
      if (timer != '0)
        timer <= timer - 1'b1; // wait for next mid-bit
      else if (bits == 4'd0)
      begin
        if (rx_in == start_bit) // possible start
        begin
          timer <= tw'(half_time);
          bits  <= 4'd1;
        end
      end
      else if ((bits == 4'd1) && (rx_in != start_bit))
        bits <= 4'd0; // glitch, back to hunting
      else if (bits == 4'(frame_bits))
      begin
        char_valid <= 1'b1;
        char_err   <= (rx_in != stop_bit);
        bits       <= 4'd0;
        if (rx_in != stop_bit)
          timer <= tw'(half_time); // let the bad stop bit pass first
      end
      else
      begin
        timer <= tw'(full_time); // next mid-bit
        bits  <= bits + 1'b1;
      end
    end
  end

  // payload only, read together with char_valid
  always_ff @(posedge clk)
  begin
    if (sample_data)
      char_data <= {rx_in, char_data[7:1]}; // lsb first
  end

  // one character per frame, and frames are far longer than a cycle
  a_valid_pulse: assert property (
    @(posedge clk) disable iff (!arst_n) char_valid |=> !char_valid
  ) else $error("serial_rx: char_valid high two cycles in a row");

endmodule

//--- uart/serial_tx.sv
`timescale 1ns/1ps
// 8N1 transmitter with its own bit timer
// accepts a byte only while idle; txd low on the cycle after acceptance
// the stop bit is held a full bit period before the next byte is taken

module serial_tx
  import uart_pkg::*;
#(
  parameter int clk_freq = 125_000_000, // Hz
  parameter int bit_freq = 7_812_500    // baud
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       in_valid,
  input  logic [7:0] in_data,
  output logic       in_ready, // high only when idle
  output logic       txd       // serial line out
);

  localparam int period    = bit_period(clk_freq, bit_freq);
  localparam int full_time = period - 1; // one bit of cycles
  localparam int tw        = $clog2(period);
  localparam int cw        = $clog2(frame_bits);

  logic [frame_bits-1:0] shreg; // frame, bit 0 on the line
  logic [tw-1:0]         timer; // cycles left in current bit
  logic [cw-1:0]         left;  // bits still to shift out
  logic                  busy;  // frame in progress
  logic                  take;  // handshake

  assign in_ready = !busy;
  assign take     = in_valid && in_ready;
  assign txd      = shreg[0]; // straight from a flop

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      shreg <= '1; // idle high
      timer <= '0;
      left  <= '0;
      busy  <= 1'b0;
    end
    else if (take)
    begin
      shreg <= {stop_bit, in_data, start_bit}; // start goes out first
      timer <= tw'(full_time);
      left  <= cw'(frame_bits - 1);
      busy  <= 1'b1;
    end
    else if (busy)
    begin
      if (timer != '0)
        timer <= timer - 1'b1;
      else if (left != '0)
      begin
        shreg <= {stop_bit, shreg[frame_bits-1:1]}; // fill with idle level
        timer <= tw'(full_time);
        left  <= left - 1'b1;
      end
      else
        busy <= 1'b0; // stop bit done
    end
  end

  // line must rest at the stop level between frames
  a_idle_high: assert property (
    @(posedge clk) disable iff (!arst_n) !busy |-> (txd == stop_bit)
  ) else $error("serial_tx: txd low while idle");

endmodule

//--- design/char_fifo.sv
`timescale 1ns/1ps
// synchronous FIFO, valid/ready on both sides
// fifo_depth must be a power of two and at least 2
// write shows on the read side one cycle later; no same-cycle bypass

module char_fifo #(
  parameter int  fifo_depth = 8,          // entries
  parameter type payload_t  = logic [7:0] // entry type
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready, // low exactly when full
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  localparam int aw = $clog2(fifo_depth);

  payload_t      mem [fifo_depth]; // storage, no reset
  logic [aw-1:0] wr_ptr;           // next slot to write
  logic [aw-1:0] rd_ptr;           // oldest entry
  logic [aw:0]   count;            // occupancy 0..fifo_depth
  logic          push;
  logic          pop;

  assign in_ready  = (count != (aw+1)'(fifo_depth));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1; // wraps, depth is 2**aw
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  // full with no read: stays full, head entry not overwritten
  a_no_write_full: assert property (
    @(posedge clk) disable iff (!arst_n)
    !in_ready && !out_ready |=> !in_ready && $stable(out_data)
  ) else $error("char_fifo: entry changed while full");

  // empty with no write: nothing appears at the read side
  a_no_read_empty: assert property (
    @(posedge clk) disable iff (!arst_n)
    !out_valid && !in_valid |=> !out_valid
  ) else $error("char_fifo: data out of an empty FIFO");

endmodule

//--- common/uart_pkg.sv
// shared definitions for the UART RTL and testbench
// 8N1 only, so no parity or word-length options live here
// bit_period truncates; pick clk_freq as a multiple of bit_freq

package uart_pkg;

  localparam logic start_bit  = 1'b0; // line level of the start bit
  localparam logic stop_bit   = 1'b1; // line level of stop bit and idle line
  localparam int   frame_bits = 10;   // start + 8 data + stop

  // one entry of the receive FIFO
  typedef struct packed {
    logic       frame_err; // stop bit sampled low
    logic [7:0] data;      // received byte
  } rx_char_t;

  // clocks per bit on the line
  function automatic int bit_period(input int clk_freq, input int bit_freq);
    return clk_freq / bit_freq;
  endfunction

endpackage
